/* logic/g729_pkg.sv */
`default_nettype none

// shared fixed-point types and limits for the energy pipeline
package g729_pkg;

	////////////////////
	// word types

	// 16 bit signed word, Q15 style
	// used for samples, shift counts, rounded result
	typedef logic signed [15:0] word16_t;

	// 32 bit signed long word
	// used for energies and shifter data
	typedef logic signed [31:0] word32_t;

	////////////////////
	// saturation limits

	localparam word32_t max_32 = 32'sh7fff_ffff;  // positive long limit
	localparam word32_t min_32 = 32'sh8000_0000;  // negative long limit
	localparam word16_t max_16 = 16'sh7fff;       // positive word limit

	// anything above this overflows when doubled
	localparam word32_t shl_in_max = 32'sh3fff_ffff;

	// round() adds half an lsb of the high word
	localparam word32_t round_bias = 32'sh0000_8000;

	// negative shift count result, all ones
	localparam word32_t neg_shift_mark = 32'shffff_ffff;

	////////////////////
	// shifter fsm

	typedef enum logic [1:0] {
		idle,      // waiting for a frame energy
		shifting,  // one bit per cycle
		hold       // result waits for downstream
	} shl_state_t;

endpackage

`default_nettype wire

/* logic/energy_acc.sv */
`default_nettype none

// input stage forming the saturating sum of 2*x*x per frame (L_mac)
module energy_acc (
	input  wire                 clk,
	input  wire                 reset,
	input  wire                 sample_valid,
	input  wire g729_pkg::word16_t sample,
	input  wire                 sample_last,   // marks final sample of a frame
	input  wire g729_pkg::word16_t frame_shift, // taken with the last sample
	input  wire                 acc_ready,
	output logic                sample_ready,
	output logic                acc_valid,
	output g729_pkg::word32_t   acc_energy,
	output g729_pkg::word16_t   acc_shift,
	output logic                acc_ovf
);

	import g729_pkg::*;

	////////////////////
	// running sum

	word32_t            sum;       // energy so far in this frame
	logic               sum_ovf;   // sticky flag set on any clamp
	word32_t            sq;        // x*x is at most 2^30
	logic signed [33:0] sum_wide;  // headroom for the unclamped add
	word32_t            sum_next;
	logic               ovf_next;
	logic               sample_fire;

	// no new samples while the frame result waits
	assign sample_ready = !acc_valid;
	assign sample_fire  = sample_valid && sample_ready;

	always_comb begin
		sq       = sample * sample;                   // 32 bit signed product
		sum_wide = 34'(sum) + (34'(sq) <<< 1);        // sum + 2*x*x
		if (sum_wide > 34'(max_32)) begin
			sum_next = max_32;                        // clamp like L_add
			ovf_next = 1'b1;
		end else begin
			sum_next = sum_wide[31:0];
			ovf_next = sum_ovf;
		end
	end

	////////////////////
	// sum and output register

	always_ff @(posedge clk) begin
		if (reset) begin
			sum        <= '0;
			sum_ovf    <= 1'b0;
			acc_valid  <= 1'b0;
			acc_energy <= '0;
			acc_shift  <= '0;
			acc_ovf    <= 1'b0;
		end else begin
			if (acc_valid && acc_ready)
				acc_valid <= 1'b0;                    // handed to the shifter
			if (sample_fire) begin
				if (sample_last) begin
					// last sample latches the result and starts fresh
					acc_energy <= sum_next;
					acc_shift  <= frame_shift;
					acc_ovf    <= ovf_next;
					acc_valid  <= 1'b1;
					sum        <= '0;
					sum_ovf    <= 1'b0;
				end else begin
					sum     <= sum_next;
					sum_ovf <= ovf_next;
				end
			end
		end
	end

	////////////////////
	// checks

	// result register holds while downstream is busy
	a_acc_stable: assert property (
		@(posedge clk) disable iff (reset)
		(acc_valid && !acc_ready) |=>
			(acc_valid && $stable(acc_energy) && $stable(acc_shift) && $stable(acc_ovf))
	);

endmodule

`default_nettype wire

/* logic/l_shl.sv */
`default_nettype none

// iterative saturating left shift (L_shl) of one bit per cycle
// result held until the next stage takes it
module l_shl (
	input  wire                 clk,
	input  wire                 reset,
	input  wire                 in_valid,
	input  wire g729_pkg::word32_t in_data,
	input  wire g729_pkg::word16_t in_shift,  // signed count
	input  wire                 in_ovf,       // overflow from upstream
	input  wire                 out_ready,
	output logic                in_ready,
	output logic                out_valid,
	output g729_pkg::word32_t   out_data,
	output logic                out_ovf
);

	import g729_pkg::*;

	shl_state_t state;
	word32_t    data;  // working value doubled each step
	word16_t    cnt;   // steps still to go
	logic       ovf;   // upstream flag carried along

	assign in_ready  = (state == idle);
	assign out_valid = (state == hold);

	////////////////////
	// fsm and datapath

	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= idle;
			data     <= '0;
			cnt      <= '0;
			ovf      <= 1'b0;
			out_data <= '0;
			out_ovf  <= 1'b0;
		end else begin
			case (state)
				idle: begin
					if (in_valid) begin
						if (in_shift[15]) begin
							// negative count sends the marker straight out
							out_data <= neg_shift_mark;
							out_ovf  <= in_ovf;
							state    <= hold;
						end else begin
							data  <= in_data;
							cnt   <= in_shift;
							ovf   <= in_ovf;
							state <= shifting;
						end
					end
				end

				shifting: begin
					if (cnt == '0) begin
						out_data <= data;  // all steps done
						out_ovf  <= ovf;
						state    <= hold;
					end else if (data > shl_in_max) begin
						// next double would wrap so stop at the limit
						out_data <= max_32;
						out_ovf  <= 1'b1;
						state    <= hold;
					end else begin
						data <= data <<< 1;
						cnt  <= cnt - 16'sd1;
					end
				end

				hold: begin
					if (out_ready)
						state <= idle;  // taken downstream
				end

				default: state <= idle;
			endcase
		end
	end

	////////////////////
	// checks

	// energies are never negative so only the marker may carry the sign bit
	a_sign_kept: assert property (
		@(posedge clk) disable iff (reset)
		(out_valid && out_data != neg_shift_mark) |-> !out_data[31]
	);

	// held result does not move until taken
	a_hold_stable: assert property (
		@(posedge clk) disable iff (reset)
		(out_valid && !out_ready) |=> (out_valid && $stable(out_data) && $stable(out_ovf))
	);

endmodule

`default_nettype wire

/* logic/round_hi.sv */
`default_nettype none

// output stage, one entry, rounded high word (round)
module round_hi (
	input  wire                 clk,
	input  wire                 reset,
	input  wire                 in_valid,
	input  wire g729_pkg::word32_t in_data,
	input  wire                 in_ovf,
	input  wire                 out_ready,
	output logic                in_ready,
	output logic                out_valid,
	output g729_pkg::word32_t   out_energy,
	output g729_pkg::word16_t   out_hi,
	output logic                out_ovf
);

	import g729_pkg::*;

	word32_t add_sum;  // in_data + bias, may wrap
	logic    add_ovf;  // wrap detect, same signs in and different out
	word16_t rnd_hi;

	// empty, or emptying this cycle
	assign in_ready = !out_valid || out_ready;

	always_comb begin
		add_sum = in_data + round_bias;
		add_ovf = (in_data[31] == round_bias[31]) && (add_sum[31] != in_data[31]);
		if (!add_ovf)
			rnd_hi = add_sum[31:16];
		else if (in_data[31])
			rnd_hi = min_32[31:16];  // negative clamp
		else
			rnd_hi = max_16;         // positive clamp
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid  <= 1'b0;
			out_energy <= '0;
			out_hi     <= '0;
			out_ovf    <= 1'b0;
		end else if (in_valid && in_ready) begin
			out_valid  <= 1'b1;
			out_energy <= in_data;
			out_hi     <= rnd_hi;
			out_ovf    <= in_ovf;  // rounding clamp not flagged
		end else if (out_ready) begin
			out_valid <= 1'b0;
		end
	end

	// stalled result stays put
	a_out_stable: assert property (
		@(posedge clk) disable iff (reset)
		(out_valid && !out_ready) |=>
			(out_valid && $stable(out_energy) && $stable(out_hi) && $stable(out_ovf))
	);

endmodule

`default_nettype wire

/* logic/energy_norm.sv */
`default_nettype none

// frame energy pipeline, accumulate then shift then round
module energy_norm (
	input  wire                 clk,
	input  wire                 reset,
	input  wire                 sample_valid,
	input  wire g729_pkg::word16_t sample,
	input  wire                 sample_last,
	input  wire g729_pkg::word16_t frame_shift,
	input  wire                 result_ready,
	output logic                sample_ready,
	output logic                result_valid,
	output g729_pkg::word32_t   result_energy,
	output g729_pkg::word16_t   result_hi,
	output logic                result_ovf
);

	import g729_pkg::*;

	////////////////////
	// stage links

	logic    acc_valid, acc_ready;  // accumulator to shifter
	word32_t acc_energy;
	word16_t acc_shift;
	logic    acc_ovf;

	logic    shl_valid, shl_ready;  // shifter to output reg
	word32_t shl_energy;
	logic    shl_ovf;

	////////////////////
	// stages

	energy_acc i_acc (
		.clk          (clk),
		.reset        (reset),
		.sample_valid (sample_valid),
		.sample       (sample),
		.sample_last  (sample_last),
		.frame_shift  (frame_shift),
		.acc_ready    (acc_ready),
		.sample_ready (sample_ready),
		.acc_valid    (acc_valid),
		.acc_energy   (acc_energy),
		.acc_shift    (acc_shift),
		.acc_ovf      (acc_ovf)
	);

	l_shl i_shl (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (acc_valid),
		.in_data   (acc_energy),
		.in_shift  (acc_shift),
		.in_ovf    (acc_ovf),
		.out_ready (shl_ready),
		.in_ready  (acc_ready),
		.out_valid (shl_valid),
		.out_data  (shl_energy),
		.out_ovf   (shl_ovf)   // acc flag or shift clamp
	);

	round_hi i_round (
		.clk        (clk),
		.reset      (reset),
		.in_valid   (shl_valid),
		.in_data    (shl_energy),
		.in_ovf     (shl_ovf),
		.out_ready  (result_ready),
		.in_ready   (shl_ready),
		.out_valid  (result_valid),
		.out_energy (result_energy),
		.out_hi     (result_hi),
		.out_ovf    (result_ovf)
	);

endmodule

`default_nettype wire

/* verif/energy_norm_model.svh */
`ifndef ENERGY_NORM_MODEL_SVH
`define ENERGY_NORM_MODEL_SVH

////////////////////
// reference ops, worked in 64 bit so nothing wraps

// one L_mac step, acc + 2*x*x, clamped at the positive long limit
function automatic longint mac_2xx(input longint acc, input int x, inout bit ovf);
	longint s;
	s = acc + 2 * longint'(x) * longint'(x);
	if (s > 64'sd2147483647) begin
		s   = 64'sd2147483647;  // L_add clamp
		ovf = 1'b1;
	end
	return s;
endfunction

// L_shl on a nonnegative energy
// negative count gives the all ones marker
function automatic logic [31:0] shl_sat(input longint e, input int n, inout bit ovf);
	longint v;
	int     i;
	v = e;
	if (n < 0)
		return 32'hffff_ffff;
	for (i = 0; i < n; i++) begin
		if (2 * v > 64'sd2147483647) begin
			ovf = 1'b1;  // next double leaves the long range
			return 32'h7fff_ffff;
		end
		v = 2 * v;
	end
	return v[31:0];
endfunction

// round(), add half an lsb of the high word, clamp, keep upper half
function automatic logic [15:0] round_word(input logic [31:0] e);
	longint s;
	s = longint'($signed(e)) + 64'sd32768;
	if (s > 64'sd2147483647)
		s = 64'sd2147483647;
	return s[31:16];
endfunction

`endif

/* verif/energy_norm_tb.sv */
`default_nettype none

module energy_norm_tb;

	import g729_pkg::*;

	`include "energy_norm_model.svh"

	////////////////////
	// frame table

	typedef struct packed {
		logic [15:0] count;  // samples in the frame
		logic        rnd;    // random samples in +-value when set
		word16_t     value;  // constant sample or random bound
		word16_t     shift;  // signed shift count
	} frame_t;

	localparam int n_frames = 16;

	localparam frame_t frame_tab [n_frames] = '{
		'{16'd8,  1'b0, 16'sd100,    16'sd0},   // plain energy without shift
		'{16'd20, 1'b1, 16'sd200,    16'sd3},
		'{16'd5,  1'b0, -16'sd300,   16'sd5},   // negative samples square up
		'{16'd1,  1'b0, 16'sd0,      16'sd20},  // zero energy with a long shift
		'{16'd4,  1'b0, 16'sd32767,  16'sd2},   // accumulator clamps
		'{16'd3,  1'b0, 16'sd32767,  16'sd0},   // max_32 into round
		'{16'd1,  1'b0, 16'sd1000,   16'sd11},  // shifter clamps
		'{16'd1,  1'b0, 16'sd1000,   16'sd10},  // just fits
		'{16'd4,  1'b0, 16'sd500,    -16'sd1},  // marker
		'{16'd3,  1'b0, 16'sd32767,  -16'sd3},  // marker keeps the acc flag
		'{16'd12, 1'b1, 16'sd3000,   16'sd4},
		'{16'd2,  1'b1, 16'sd30000,  16'sd1},
		'{16'd6,  1'b1, 16'sd1000,   16'sd7},
		'{16'd1,  1'b0, -16'sd32768, 16'sd0},   // 2*x*x hits 2^31
		'{16'd30, 1'b1, 16'sd800,    16'sd9},
		'{16'd10, 1'b1, 16'sd50,     16'sd25}
	};

	logic    clk, reset, sample_valid, sample_last, result_ready;
	logic    sample_ready, result_valid, result_ovf;
	word16_t sample, frame_shift, result_hi;
	word32_t result_energy;

	word32_t exp_energy[$], obs_energy[$];
	word16_t exp_hi[$], obs_hi[$];
	logic    exp_ovf[$], obs_ovf[$];

	energy_norm i_energy_norm (
		.clk           (clk),
		.reset         (reset),
		.sample_valid  (sample_valid),
		.sample        (sample),
		.sample_last   (sample_last),
		.frame_shift   (frame_shift),
		.result_ready  (result_ready),
		.sample_ready  (sample_ready),
		.result_valid  (result_valid),
		.result_energy (result_energy),
		.result_hi     (result_hi),
		.result_ovf    (result_ovf)
	);

	always #5 clk = ~clk;

	////////////////////
	// helpers

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected) begin
			$display("error at time %0t: %s is %h, expected %h", $time, what, got, expected);
			$display("Checks failed");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	// called on a falling edge and returns on the falling edge after the transfer
	task automatic send_sample(input int s, input bit last, input word16_t shift);
		sample_valid = 1'b1;
		sample       = s[15:0];
		sample_last  = last;
		frame_shift  = shift;
		while (!sample_ready)
			@(negedge clk);  // input stalled behind a finished frame
		@(negedge clk);
		sample_valid = 1'b0;
		sample_last  = 1'b0;
	endtask

	// random back-pressure with each transfer seen one half cycle ahead
	always @(negedge clk) begin
		result_ready = ($urandom % 3) != 0;
		if (!reset && result_valid && result_ready) begin
			obs_energy.push_back(result_energy);
			obs_hi.push_back(result_hi);
			obs_ovf.push_back(result_ovf);
		end
	end

	////////////////////
	// driver and final compare

	initial begin
		frame_t ent;
		int     f, i, s, v;
		longint acc;
		bit     ovf;
		word32_t e;
		void'($urandom(37859));
		clk          = 1'b0;
		reset        = 1'b1;
		sample_valid = 1'b0;
		sample       = '0;
		sample_last  = 1'b0;
		frame_shift  = '0;
		result_ready = 1'b0;
		repeat (10) @(negedge clk);
		reset = 1'b0;

		for (f = 0; f < n_frames; f++) begin
			ent = frame_tab[f];
			v   = int'(ent.value);
			acc = 0;
			ovf = 1'b0;
			for (i = 0; i < ent.count; i++) begin
				if (ent.rnd)
					s = int'($urandom % (2 * v + 1)) - v;
				else
					s = v;
				acc = mac_2xx(acc, s, ovf);
				send_sample(s, i == ent.count - 1, ent.shift);
				if ($urandom % 4 == 0)
					@(negedge clk);  // idle gap
			end
			e = shl_sat(acc, int'(ent.shift), ovf);
			exp_energy.push_back(e);
			exp_hi.push_back(round_word(e));
			exp_ovf.push_back(ovf);
		end

		while (obs_energy.size() < n_frames)
			@(negedge clk);
		repeat (30) @(negedge clk);  // any extra frame shows up here
		check_value("frame count", obs_energy.size(), n_frames);
		for (f = 0; f < n_frames; f++) begin
			check_value($sformatf("frame %0d energy", f), obs_energy[f], exp_energy[f]);
			check_value($sformatf("frame %0d high word", f), obs_hi[f], exp_hi[f]);
			check_value($sformatf("frame %0d overflow", f), obs_ovf[f], exp_ovf[f]);
		end

		$display("All checks passed");
		$finish;
	end

	////////////////////
	// watchdog

	initial begin
		longint samples, limit;
		int     f;
		samples = 0;
		for (f = 0; f < n_frames; f++)
			samples += frame_tab[f].count;
		limit = (samples + 40 * n_frames + 10) * 10 * 4;  // cycles times period times margin
		#(limit);
		$display("timeout, the pipeline stopped delivering frames before the run ended");
		$display("Checks failed");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

/* energy_norm.f */
+incdir+verif
logic/g729_pkg.sv
logic/energy_acc.sv
logic/l_shl.sv
logic/round_hi.sv
logic/energy_norm.sv
verif/energy_norm_tb.sv
